/* logic/dmaPkg.sv */
package dmaPkg;

  // four channels, fixed by the register map
  localparam int numChannels = 4;

  // transfer address and word count width
  localparam int addrWidth = 16;

  // cpu register address width
  localparam int regAddrWidth = 4;

  // channel n address at 2n, count at 2n+1
  // address 8 is command on write, status on read
  localparam logic [regAddrWidth-1:0] regCmd = 4'd8;
  localparam logic [regAddrWidth-1:0] regMode = 4'd11;
  localparam logic [regAddrWidth-1:0] regClearFf = 4'd12;

  // transfer type field of the mode register
  localparam logic [1:0] transferWrite = 2'b01;
  localparam logic [1:0] transferRead = 2'b10;

  // one-hot transfer states, S3 kept for the full encoding
  typedef enum logic [5:0] {
    stateSi = 6'b000001,
    stateSo = 6'b000010,
    stateS1 = 6'b000100,
    stateS2 = 6'b001000,
    stateS3 = 6'b010000,
    stateS4 = 6'b100000
  } dmaState;

  // written data byte, seen as command or as mode word
  typedef union packed {
    struct packed {
      logic [2:0] unusedHigh;
      logic priorityType;
      logic unusedBit3;
      logic controllerDisable;
      logic [1:0] unusedLow;
    } cmd;
    struct packed {
      logic [3:0] unusedHigh;
      logic [1:0] transferType;
      logic [1:0] channelSelect;
    } mode;
  } commandModeWord;

endpackage

/* logic/dmaRegisters.sv */
`timescale 1ns/1ns

module dmaRegisters
(
  input  logic busIf,
  input  logic arstN,
  input  logic csN,
  input  logic cpuRdN,
  input  logic cpuWrN,
  input  logic [dmaPkg::regAddrWidth-1:0] regAddr,
  input  logic [7:0] dataIn,
  input  logic [dmaPkg::numChannels-1:0] drq,
  input  logic transferDone,
  input  logic [$clog2(dmaPkg::numChannels)-1:0] channelSel,
  output logic [7:0] dataOut,
  output logic [dmaPkg::numChannels-1:0] activeReq,
  output logic rotateEn,
  output logic isRead,
  output logic [dmaPkg::addrWidth-1:0] addrOut
);

  localparam int chanBits = $clog2(dmaPkg::numChannels);

  // per channel current address and count
  logic [dmaPkg::addrWidth-1:0] curAddr [dmaPkg::numChannels];
  logic [dmaPkg::addrWidth-1:0] curCount [dmaPkg::numChannels];
  logic [1:0] transferType [dmaPkg::numChannels];

  dmaPkg::commandModeWord commandReg;
  dmaPkg::commandModeWord wordIn;
  logic bytePtr;
  logic [dmaPkg::numChannels-1:0] tcFlag;
  logic [dmaPkg::numChannels-1:0] mask;

  logic wrEn;
  logic rdEn;
  logic chanReg;
  logic [chanBits-1:0] regChannel;
  logic addrWrite;
  logic countWrite;
  logic cmdWrite;
  logic modeWrite;
  logic clearFfWrite;
  logic statusRead;
  logic byteAccess;
  logic [dmaPkg::addrWidth-1:0] selWord;
  logic [7:0] statusByte;

  assign wordIn = dataIn;

  // cpu access decode
  assign wrEn = !csN && !cpuWrN;
  assign rdEn = !csN && !cpuRdN;
  // lower half of the map holds the address and count pairs
  assign chanReg = regAddr < dmaPkg::regAddrWidth'(2 * dmaPkg::numChannels);
  assign regChannel = regAddr[chanBits:1];
  assign addrWrite = wrEn && chanReg && !regAddr[0];
  assign countWrite = wrEn && chanReg && regAddr[0];
  assign cmdWrite = wrEn && (regAddr == dmaPkg::regCmd);
  assign modeWrite = wrEn && (regAddr == dmaPkg::regMode);
  assign clearFfWrite = wrEn && (regAddr == dmaPkg::regClearFf);
  assign statusRead = rdEn && (regAddr == dmaPkg::regCmd);
  // every byte access to a pair moves the pointer
  assign byteAccess = (wrEn || rdEn) && chanReg;

  // request lines on top of the terminal counts
  assign statusByte = {drq, tcFlag};
  assign selWord = regAddr[0] ? curCount[regChannel] : curAddr[regChannel];

  // combinational read port
  always_comb
  begin
    dataOut = '0;
    if (rdEn)
    begin
      if (chanReg)
        dataOut = bytePtr ? selWord[dmaPkg::addrWidth-1:8] : selWord[7:0];
      else if (regAddr == dmaPkg::regCmd)
        dataOut = statusByte;
    end
  end

  // masked requests go to arbitration unless the controller is disabled
  assign activeReq = commandReg.cmd.controllerDisable ? '0 : (drq & ~mask);
  assign rotateEn = commandReg.cmd.priorityType;
  assign isRead = (transferType[channelSel] == dmaPkg::transferRead);
  assign addrOut = curAddr[channelSel];

  // address and count registers
  always_ff @(posedge busIf or negedge arstN)
  begin
    if (!arstN)
    begin
      for (int i = 0; i < dmaPkg::numChannels; i++)
      begin
        curAddr[i] <= '0;
        curCount[i] <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < dmaPkg::numChannels; i++)
      begin
        // step the served channel at the end of its transfer
        if (transferDone && (channelSel == i))
        begin
          curAddr[i] <= curAddr[i] + 1'b1;
          curCount[i] <= curCount[i] - 1'b1;
        end
        // cpu write loads the byte picked by the byte pointer
        if (addrWrite && (regChannel == i))
        begin
          if (bytePtr)
            curAddr[i][dmaPkg::addrWidth-1:8] <= dataIn;
          else
            curAddr[i][7:0] <= dataIn;
        end
        if (countWrite && (regChannel == i))
        begin
          if (bytePtr)
            curCount[i][dmaPkg::addrWidth-1:8] <= dataIn;
          else
            curCount[i][7:0] <= dataIn;
        end
      end
    end
  end

  // command, mode, byte pointer, tc and mask
  always_ff @(posedge busIf or negedge arstN)
  begin
    if (!arstN)
    begin
      commandReg <= '0;
      bytePtr <= 1'b0;
      tcFlag <= '0;
      mask <= '0;
      for (int i = 0; i < dmaPkg::numChannels; i++)
        transferType[i] <= 2'b00;
    end
    else
    begin
      if (cmdWrite)
        commandReg <= wordIn;
      if (modeWrite)
        transferType[wordIn.mode.channelSelect] <= wordIn.mode.transferType;
      if (clearFfWrite)
        bytePtr <= 1'b0;
      else if (byteAccess)
        bytePtr <= !bytePtr;
      // a new tc on the same edge as a status read still lands
      if (statusRead)
        tcFlag <= '0;
      for (int i = 0; i < dmaPkg::numChannels; i++)
      begin
        if (countWrite && (regChannel == i))
          mask[i] <= 1'b0;
        // count wraps past zero so a channel gets n+1 transfers
        if (transferDone && (channelSel == i) && (curCount[i] == '0))
        begin
          tcFlag[i] <= 1'b1;
          mask[i] <= 1'b1;
        end
      end
    end
  end

  // tc flags gone one cycle after a status read
  tcClearedAfterRead: assert property (@(posedge busIf) disable iff (!arstN)
    (statusRead && !transferDone) |=> (tcFlag == '0));

endmodule

/* logic/dmaPriority.sv */
`timescale 1ns/1ns

module dmaPriority
(
  input  logic busIf,
  input  logic arstN,
  input  logic [dmaPkg::numChannels-1:0] activeReq,
  input  logic rotateEn,
  input  logic transferDone,
  input  logic grantLatch,
  output logic [dmaPkg::numChannels-1:0] grant,
  output logic [$clog2(dmaPkg::numChannels)-1:0] channelSel
);

  localparam int chanBits = $clog2(dmaPkg::numChannels);

  // position 0 holds the highest priority channel
  logic [chanBits-1:0] priorityOrder [dmaPkg::numChannels];
  logic [chanBits-1:0] nextOrder [dmaPkg::numChannels];
  logic [chanBits-1:0] winner;
  logic winnerValid;
  logic [chanBits-1:0] servedPos;

  // scan from lowest to highest so the top entry wins
  always_comb
  begin
    winner = '0;
    winnerValid = 1'b0;
    for (int p = dmaPkg::numChannels - 1; p >= 0; p--)
    begin
      if (activeReq[priorityOrder[p]])
      begin
        winner = priorityOrder[p];
        winnerValid = 1'b1;
      end
    end
    grant = '0;
    if (winnerValid)
      grant[winner] = 1'b1;
  end

  // where the channel being served sits in the order
  always_comb
  begin
    servedPos = '0;
    for (int p = 0; p < dmaPkg::numChannels; p++)
    begin
      if (priorityOrder[p] == channelSel)
        servedPos = chanBits'(p);
    end
  end

  // rotate so the served channel drops to the bottom
  // fixed mode pins the order at 0,1,2,3
  always_comb
  begin
    for (int i = 0; i < dmaPkg::numChannels; i++)
      nextOrder[i] = rotateEn ? priorityOrder[chanBits'(i + servedPos + 1)] : chanBits'(i);
  end

  always_ff @(posedge busIf or negedge arstN)
  begin
    if (!arstN)
    begin
      for (int i = 0; i < dmaPkg::numChannels; i++)
        priorityOrder[i] <= chanBits'(i);
    end
    else if (!rotateEn || transferDone)
      priorityOrder <= nextOrder;
  end

  // selection frozen once the state leaves SI
  always_ff @(posedge busIf or negedge arstN)
  begin
    if (!arstN)
      channelSel <= '0;
    else if (grantLatch && winnerValid)
      channelSel <= winner;
  end

  grantLegal: assert property (@(posedge busIf) disable iff (!arstN)
    $onehot0(grant) && ((grant & ~activeReq) == '0));

endmodule

/* logic/dmaTiming.sv */
`timescale 1ns/1ns

module dmaTiming
(
  input  logic busIf,
  input  logic arstN,
  input  logic [dmaPkg::numChannels-1:0] grant,
  input  logic hlda,
  input  logic isRead,
  output logic hrq,
  output logic aen,
  output logic adstb,
  output logic [dmaPkg::numChannels-1:0] dack,
  output logic iorN,
  output logic iowN,
  output logic memrN,
  output logic memwN,
  output logic grantLatch,
  output logic transferDone
);

  dmaPkg::dmaState state;
  dmaPkg::dmaState nextState;
  logic [dmaPkg::numChannels-1:0] grantReg;
  logic strobeActive;

  // single transfer sequence SI SO S1 S2 S4
  always_comb
  begin
    nextState = state;
    case (state)
      dmaPkg::stateSi:
      begin
        if (|grant)
          nextState = dmaPkg::stateSo;
      end
      dmaPkg::stateSo:
      begin
        // hold request until the cpu gives up the bus
        if (hlda)
          nextState = dmaPkg::stateS1;
      end
      dmaPkg::stateS1:
        nextState = dmaPkg::stateS2;
      dmaPkg::stateS2:
        nextState = dmaPkg::stateS4;
      dmaPkg::stateS4:
        nextState = dmaPkg::stateSi;
      // no compressed timing, S3 falls back to idle
      dmaPkg::stateS3:
        nextState = dmaPkg::stateSi;
      default:
        nextState = dmaPkg::stateSi;
    endcase
  end

  always_ff @(posedge busIf or negedge arstN)
  begin
    if (!arstN)
      state <= dmaPkg::stateSi;
    else
      state <= nextState;
  end

  // channel captured on the SI to SO edge
  always_ff @(posedge busIf or negedge arstN)
  begin
    if (!arstN)
      grantReg <= '0;
    else if ((state == dmaPkg::stateSi) && (|grant))
      grantReg <= grant;
  end

  // bus control decoded from the state
  assign grantLatch = (state == dmaPkg::stateSi);
  assign transferDone = (state == dmaPkg::stateS4);
  assign hrq = (state != dmaPkg::stateSi);
  assign aen = (state == dmaPkg::stateS1) || (state == dmaPkg::stateS2);
  assign adstb = (state == dmaPkg::stateS1);
  assign strobeActive = (state == dmaPkg::stateS2);
  assign dack = strobeActive ? grantReg : '0;

  // read moves memory to io, write moves io to memory
  assign memrN = !(strobeActive && isRead);
  assign iowN = !(strobeActive && isRead);
  assign iorN = !(strobeActive && !isRead);
  assign memwN = !(strobeActive && !isRead);

  adstbSingleCycle: assert property (@(posedge busIf) disable iff (!arstN)
    $rose(adstb) |=> !adstb);

  ioStrobesExclusive: assert property (@(posedge busIf) disable iff (!arstN)
    !(!iorN && !iowN));

  // aen covers S1 and S2 only
  aenTwoCycles: assert property (@(posedge busIf) disable iff (!arstN)
    $rose(aen) |=> ##1 $fell(aen));

endmodule

/* logic/dma8237.sv */
`timescale 1ns/1ns

module dma8237
(
  input  logic busIf,
  input  logic arstN,
  input  logic csN,
  input  logic cpuRdN,
  input  logic cpuWrN,
  input  logic [dmaPkg::regAddrWidth-1:0] regAddr,
  input  logic [7:0] dataIn,
  input  logic [dmaPkg::numChannels-1:0] drq,
  input  logic hlda,
  output logic [7:0] dataOut,
  output logic hrq,
  output logic aen,
  output logic adstb,
  output logic [dmaPkg::numChannels-1:0] dack,
  output logic [dmaPkg::addrWidth-1:0] addrOut,
  output logic iorN,
  output logic iowN,
  output logic memrN,
  output logic memwN
);

  // block to block wires
  logic [dmaPkg::numChannels-1:0] activeReq;
  logic rotateEn;
  logic isRead;
  logic [dmaPkg::numChannels-1:0] grant;
  logic [$clog2(dmaPkg::numChannels)-1:0] channelSel;
  logic grantLatch;
  logic transferDone;

  // cpu port and channel state
  dmaRegisters regs
  (
    .busIf(busIf),
    .arstN(arstN),
    .csN(csN),
    .cpuRdN(cpuRdN),
    .cpuWrN(cpuWrN),
    .regAddr(regAddr),
    .dataIn(dataIn),
    .drq(drq),
    .transferDone(transferDone),
    .channelSel(channelSel),
    .dataOut(dataOut),
    .activeReq(activeReq),
    .rotateEn(rotateEn),
    .isRead(isRead),
    .addrOut(addrOut)
  );

  // channel arbitration
  dmaPriority arbiter
  (
    .busIf(busIf),
    .arstN(arstN),
    .activeReq(activeReq),
    .rotateEn(rotateEn),
    .transferDone(transferDone),
    .grantLatch(grantLatch),
    .grant(grant),
    .channelSel(channelSel)
  );

  // transfer FSM and bus strobes
  dmaTiming timing
  (
    .busIf(busIf),
    .arstN(arstN),
    .grant(grant),
    .hlda(hlda),
    .isRead(isRead),
    .hrq(hrq),
    .aen(aen),
    .adstb(adstb),
    .dack(dack),
    .iorN(iorN),
    .iowN(iowN),
    .memrN(memrN),
    .memwN(memwN),
    .grantLatch(grantLatch),
    .transferDone(transferDone)
  );

endmodule

/* sim/dmaTb.sv */
`timescale 1ns/1ns

module dmaTb;

  logic busIf;
  logic arstN;
  logic csN;
  logic cpuRdN;
  logic cpuWrN;
  logic [dmaPkg::regAddrWidth-1:0] regAddr;
  logic [7:0] dataIn;
  logic [dmaPkg::numChannels-1:0] drq;
  logic hlda;
  logic [7:0] dataOut;
  logic hrq;
  logic aen;
  logic adstb;
  logic [dmaPkg::numChannels-1:0] dack;
  logic [dmaPkg::addrWidth-1:0] addrOut;
  logic iorN;
  logic iowN;
  logic memrN;
  logic memwN;

  // testbench view of the channel state
  logic [15:0] modelAddr [4];
  logic [15:0] modelCount [4];
  logic [1:0] modelType [4];
  logic [3:0] maskModel;
  logic [3:0] tcModel;
  // two bits per slot with slot 0 the highest priority
  logic [7:0] orderModel;
  logic rotating;
  logic [3:0] dackLog [$];
  int xferCount;
  int errors;
  int checks;
  int testsRun;
  int holdDelay;

  dma8237 UUT
  (
    .busIf(busIf),
    .arstN(arstN),
    .csN(csN),
    .cpuRdN(cpuRdN),
    .cpuWrN(cpuWrN),
    .regAddr(regAddr),
    .dataIn(dataIn),
    .drq(drq),
    .hlda(hlda),
    .dataOut(dataOut),
    .hrq(hrq),
    .aen(aen),
    .adstb(adstb),
    .dack(dack),
    .addrOut(addrOut),
    .iorN(iorN),
    .iowN(iowN),
    .memrN(memrN),
    .memwN(memwN)
  );

  always #50 busIf = ~busIf;

  // first unmasked request in priority order wins
  function automatic logic [3:0] expectedGrant(input logic [3:0] req, input logic [3:0] maskBits,
    input logic [7:0] order, input logic rot);
    logic [3:0] pending;
    logic [3:0] result;
    logic [1:0] chan;
    logic found;
    pending = req & ~maskBits;
    result = '0;
    found = 1'b0;
    for (int p = 0; p < 4; p++)
    begin
      // fixed mode means channel number is the rank
      chan = rot ? order[2*p +: 2] : 2'(p);
      if (!found && pending[chan])
      begin
        result[chan] = 1'b1;
        found = 1'b1;
      end
    end
    return result;
  endfunction

  // served channel taken out and put last
  function automatic logic [7:0] rotatedOrder(input logic [7:0] order, input logic [1:0] served);
    logic [7:0] result;
    int slot;
    result = '0;
    slot = 0;
    for (int p = 0; p < 4; p++)
    begin
      if (order[2*p +: 2] != served)
      begin
        result[2*slot +: 2] = order[2*p +: 2];
        slot++;
      end
    end
    result[7:6] = served;
    return result;
  endfunction

  task automatic reportMismatch(input string name, input logic [15:0] expected,
    input logic [15:0] actual);
    $display("mismatch at %0t ns: %s expected %h got %h", $time, name, expected, actual);
    errors++;
  endtask

  task automatic reportFailure(input string what);
    $display("error at %0t ns: %s", $time, what);
    errors++;
  endtask

  task automatic finishRun();
    $display("summary: %0d tests, %0d checks, %0d errors", testsRun, checks, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  endtask

  task automatic testDone(input string name, input int errorsBefore);
    testsRun++;
    if (errors == errorsBefore)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, errors - errorsBefore);
  endtask

  // one write cycle that lands on the second edge
  task automatic cpuWrite(input logic [3:0] addr, input logic [7:0] data);
    @(posedge busIf);
    csN <= 1'b0;
    cpuWrN <= 1'b0;
    regAddr <= addr;
    dataIn <= data;
    @(posedge busIf);
    csN <= 1'b1;
    cpuWrN <= 1'b1;
  endtask

  // read data sampled mid cycle while the strobe is low
  task automatic cpuRead(input logic [3:0] addr, output logic [7:0] data);
    @(posedge busIf);
    csN <= 1'b0;
    cpuRdN <= 1'b0;
    regAddr <= addr;
    @(negedge busIf);
    data = dataOut;
    @(posedge busIf);
    csN <= 1'b1;
    cpuRdN <= 1'b1;
  endtask

  task automatic setCommand(input logic rot);
    dmaPkg::commandModeWord cmdWord;
    cmdWord = '0;
    cmdWord.cmd.priorityType = rot;
    cpuWrite(dmaPkg::regCmd, cmdWord);
    rotating = rot;
    // rotation starts from the fixed order 0,1,2,3
    orderModel = 8'he4;
  endtask

  task automatic programChannel(input int ch, input logic [15:0] addr, input logic [15:0] count,
    input logic [1:0] ttype);
    dmaPkg::commandModeWord modeWord;
    cpuWrite(dmaPkg::regClearFf, 8'h00);
    cpuWrite(4'(2 * ch), addr[7:0]);
    cpuWrite(4'(2 * ch), addr[15:8]);
    cpuWrite(4'(2 * ch + 1), count[7:0]);
    cpuWrite(4'(2 * ch + 1), count[15:8]);
    modeWord = '0;
    modeWord.mode.channelSelect = 2'(ch);
    modeWord.mode.transferType = ttype;
    cpuWrite(dmaPkg::regMode, modeWord);
    modelAddr[ch] = addr;
    modelCount[ch] = count;
    modelType[ch] = ttype;
    // count write unmasks the channel
    maskModel[ch] = 1'b0;
  endtask

  task automatic waitTransfers(input int target);
    int cycles;
    cycles = 0;
    while (xferCount < target && cycles < 400)
    begin
      @(posedge busIf);
      cycles++;
    end
    if (xferCount < target)
    begin
      reportFailure("timeout, the expected transfer never came");
      finishRun();
    end
  endtask

  task automatic waitIdle();
    int cycles;
    cycles = 0;
    while (hrq && cycles < 50)
    begin
      @(posedge busIf);
      cycles++;
    end
    if (hrq)
    begin
      reportFailure("timeout, hrq stayed high");
      finishRun();
    end
  endtask

  // bus master grants hold after 0 to 3 cycles
  always @(posedge busIf)
  begin
    if (!arstN)
    begin
      hlda <= 1'b0;
      holdDelay <= 0;
    end
    else if (!hrq)
    begin
      hlda <= 1'b0;
      holdDelay <= $urandom_range(3, 0);
    end
    else if (!hlda)
    begin
      if (holdDelay == 0)
        hlda <= 1'b1;
      else
        holdDelay <= holdDelay - 1;
    end
  end

  // every transfer is checked in its dack cycle before the model steps
  always @(negedge busIf)
  begin : transferCheck
    logic [3:0] expected;
    logic [1:0] chan;
    logic expRead;
    if (arstN && (|dack))
    begin
      expected = expectedGrant(drq, maskModel, orderModel, rotating);
      checks++;
      dackLog.push_back(dack);
      if (dack !== expected)
        reportMismatch("dack", expected, dack);
      if (expected == '0)
      begin
        reportFailure("dack raised with no eligible request");
      end
      else
      begin
        chan = '0;
        for (int i = 0; i < 4; i++)
        begin
          if (expected[i])
            chan = 2'(i);
        end
        if (addrOut !== modelAddr[chan])
          reportMismatch("addrOut", modelAddr[chan], addrOut);
        // read moves memory to io and write moves io to memory
        expRead = (modelType[chan] == dmaPkg::transferRead);
        if (memrN !== !expRead)
          reportMismatch("memrN", !expRead, memrN);
        if (iowN !== !expRead)
          reportMismatch("iowN", !expRead, iowN);
        if (iorN !== expRead)
          reportMismatch("iorN", expRead, iorN);
        if (memwN !== expRead)
          reportMismatch("memwN", expRead, memwN);
        modelAddr[chan] = modelAddr[chan] + 1'b1;
        // terminal count when the count was already zero
        if (modelCount[chan] == '0)
        begin
          tcModel[chan] = 1'b1;
          maskModel[chan] = 1'b1;
        end
        modelCount[chan] = modelCount[chan] - 1'b1;
        if (rotating)
          orderModel = rotatedOrder(orderModel, chan);
      end
      xferCount++;
    end
  end

  initial
  begin
    int seedValue;
    int errorsBefore;
    int startCount;
    int n;
    logic [7:0] readByte;
    logic hrqSeen;
    seedValue = $urandom(32'hb0d5_07e3);
    busIf = 1'b0;
    arstN = 1'b0;
    csN = 1'b1;
    cpuRdN = 1'b1;
    cpuWrN = 1'b1;
    regAddr = '0;
    dataIn = '0;
    drq = '0;
    hlda = 1'b0;
    maskModel = '0;
    tcModel = '0;
    orderModel = 8'he4;
    rotating = 1'b0;
    xferCount = 0;
    errors = 0;
    checks = 0;
    testsRun = 0;
    for (int i = 0; i < 4; i++)
    begin
      modelAddr[i] = '0;
      modelCount[i] = '0;
      modelType[i] = 2'b00;
    end
    repeat (2) @(posedge busIf);
    arstN <= 1'b1;

    // reset values and an empty status
    errorsBefore = errors;
    @(negedge busIf);
    checks++;
    if (hrq !== 1'b0)
      reportMismatch("hrq", 0, hrq);
    if (aen !== 1'b0)
      reportMismatch("aen", 0, aen);
    if (adstb !== 1'b0)
      reportMismatch("adstb", 0, adstb);
    if (dack !== 4'b0000)
      reportMismatch("dack", 0, dack);
    if ({iorN, iowN, memrN, memwN} !== 4'b1111)
      reportMismatch("strobes", 4'hf, {iorN, iowN, memrN, memwN});
    cpuRead(dmaPkg::regCmd, readByte);
    if (readByte !== 8'h00)
      reportMismatch("status", 8'h00, readByte);
    testDone("reset state", errorsBefore);

    // byte-wise register write and readback
    errorsBefore = errors;
    for (int ch = 0; ch < 4; ch++)
      programChannel(ch, 16'($urandom), 16'($urandom), dmaPkg::transferWrite);
    cpuWrite(dmaPkg::regClearFf, 8'h00);
    for (int ch = 0; ch < 4; ch++)
    begin
      checks++;
      cpuRead(4'(2 * ch), readByte);
      if (readByte !== modelAddr[ch][7:0])
        reportMismatch("address low", modelAddr[ch][7:0], readByte);
      cpuRead(4'(2 * ch), readByte);
      if (readByte !== modelAddr[ch][15:8])
        reportMismatch("address high", modelAddr[ch][15:8], readByte);
      cpuRead(4'(2 * ch + 1), readByte);
      if (readByte !== modelCount[ch][7:0])
        reportMismatch("count low", modelCount[ch][7:0], readByte);
      cpuRead(4'(2 * ch + 1), readByte);
      if (readByte !== modelCount[ch][15:8])
        reportMismatch("count high", modelCount[ch][15:8], readByte);
    end
    testDone("register readback", errorsBefore);

    // fixed priority with random request patterns
    errorsBefore = errors;
    setCommand(1'b0);
    for (int ch = 0; ch < 4; ch++)
      programChannel(ch, 16'($urandom), 16'h00ff, dmaPkg::transferWrite);
    for (int i = 0; i < 12; i++)
    begin
      drq <= 4'($urandom_range(15, 1));
      waitTransfers(xferCount + 1);
      drq <= '0;
      waitIdle();
    end
    testDone("fixed priority", errorsBefore);

    // rotating priority walks all four channels
    errorsBefore = errors;
    setCommand(1'b1);
    dackLog.delete();
    drq <= 4'b1111;
    waitTransfers(xferCount + 4);
    drq <= '0;
    waitIdle();
    for (int i = 0; i < 4; i++)
    begin
      if (dackLog[i] !== (4'b0001 << i))
        reportMismatch("rotation dack", 4'b0001 << i, dackLog[i]);
    end
    setCommand(1'b0);
    testDone("rotating priority", errorsBefore);

    // read then write strobes on channel 1
    errorsBefore = errors;
    programChannel(1, 16'($urandom), 16'h0010, dmaPkg::transferRead);
    drq <= 4'b0010;
    waitTransfers(xferCount + 1);
    drq <= '0;
    waitIdle();
    programChannel(1, 16'($urandom), 16'h0010, dmaPkg::transferWrite);
    drq <= 4'b0010;
    waitTransfers(xferCount + 1);
    drq <= '0;
    waitIdle();
    testDone("transfer strobes", errorsBefore);

    // count n gives n+1 transfers before tc and mask
    errorsBefore = errors;
    n = $urandom_range(4, 1);
    programChannel(2, 16'($urandom), 16'(n), dmaPkg::transferRead);
    startCount = xferCount;
    drq <= 4'b0100;
    waitTransfers(startCount + n + 1);
    waitIdle();
    hrqSeen = 1'b0;
    for (int i = 0; i < 8; i++)
    begin
      @(posedge busIf);
      if (hrq)
        hrqSeen = 1'b1;
    end
    if (hrqSeen)
      reportFailure("masked channel 2 raised hrq after terminal count");
    if (xferCount !== startCount + n + 1)
      reportMismatch("transfer count", 16'(startCount + n + 1), 16'(xferCount));
    checks++;
    cpuRead(dmaPkg::regCmd, readByte);
    if (readByte !== {drq, tcModel})
      reportMismatch("status", {drq, tcModel}, readByte);
    if (!readByte[2])
      reportFailure("channel 2 TC status bit not set after terminal count");
    // status read clears every tc flag
    tcModel = '0;
    cpuRead(dmaPkg::regCmd, readByte);
    if (readByte !== {drq, tcModel})
      reportMismatch("status after clear", {drq, tcModel}, readByte);
    drq <= '0;
    testDone("terminal count", errorsBefore);

    finishRun();
  end

endmodule

/* tb.f */
logic/dmaPkg.sv
logic/dmaRegisters.sv
logic/dmaPriority.sv
logic/dmaTiming.sv
logic/dma8237.sv
sim/dmaTb.sv

/* Bender.yml */
package:
  name: dma8237

sources:
  - logic/dmaPkg.sv
  - logic/dmaRegisters.sv
  - logic/dmaPriority.sv
  - logic/dmaTiming.sv
  - logic/dma8237.sv
  - target: simulation
    files:
      - sim/dmaTb.sv
